//--- include/rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

// alu funct3 codes
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101

`endif

//--- src/rv32i_pkg.sv
`include "rv32i_consts.svh"

package rv32i_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // jal and jalr always taken
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JAL,
        BR_JALR
    } br_op_e;

    typedef enum logic [1:0] {
        OP1_REG,
        OP1_PC,
        OP1_ZERO    // lui
    } op_sel_e;

endpackage

//--- src/pc_reg.sv
`include "rv32i_consts.svh"

module pc_reg (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             pc_step_i,
    input  logic             jump_flag_i,
    input  rv32i_pkg::word_t jump_addr_i,
    output rv32i_pkg::word_t pc_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= `RESET_PC;
        end else if (jump_flag_i) begin
            pc_o <= jump_addr_i;        // jump beats step
        end else if (pc_step_i) begin
            pc_o <= pc_o + 32'd4;
        end
    end

    // a jalr target with bit 1 set would land here
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (reset_i)
        pc_o[1:0] == 2'b00
    );

endmodule

//--- src/fetch_fsm.sv
module fetch_fsm (
    input  logic             clk,
    input  logic             reset_i,
    input  rv32i_pkg::word_t pc_i,
    input  logic             jump_flag_i,
    output rv32i_pkg::word_t o_inst_addr_o,
    output logic             o_inst_read_o,
    input  logic             i_inst_waitrequest_i,
    input  rv32i_pkg::word_t i_inst_readdata_i,
    input  logic             i_inst_readdata_valid_i,
    output logic             pc_step_o,
    output rv32i_pkg::word_t inst_o,
    output rv32i_pkg::word_t inst_addr_o,
    output logic             inst_valid_o
);

    typedef enum logic [1:0] {
        ST_REQ,
        ST_WAIT,
        ST_DROP     // swallow a wrong-path response
    } state_e;

    state_e           state_q;
    logic             stale_q;      // pending request overtaken by a jump
    logic             hold_q;       // last request stalled on waitrequest
    rv32i_pkg::word_t hold_addr_q;
    rv32i_pkg::word_t req_addr_q;   // address of the outstanding request
    logic             resp_ok;
    logic             accept;

    // a response during a jump belongs to the old path
    assign resp_ok = (state_q == ST_WAIT) && i_inst_readdata_valid_i && !jump_flag_i;

    assign o_inst_read_o = (state_q == ST_REQ) || resp_ok;   // overlap with execute
    assign o_inst_addr_o = hold_q ? hold_addr_q : pc_i;      // pc may jump under a stall
    assign accept        = o_inst_read_o && !i_inst_waitrequest_i;
    assign pc_step_o     = accept && !stale_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= ST_REQ;
            stale_q      <= 1'b0;
            hold_q       <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            hold_q       <= o_inst_read_o && i_inst_waitrequest_i;
            inst_valid_o <= resp_ok;
            case (state_q)
                ST_REQ: begin
                    if (accept) begin
                        stale_q <= 1'b0;
                        state_q <= (stale_q || jump_flag_i) ? ST_DROP : ST_WAIT;
                    end else if (jump_flag_i) begin
                        stale_q <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (i_inst_readdata_valid_i) begin
                        state_q <= accept ? ST_WAIT : ST_REQ;
                    end else if (jump_flag_i) begin
                        state_q <= ST_DROP;
                    end
                end
                ST_DROP: begin
                    if (i_inst_readdata_valid_i) begin
                        state_q <= ST_REQ;  // pc already holds the target
                    end
                end
                default: state_q <= ST_REQ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_inst_read_o && i_inst_waitrequest_i) begin
            hold_addr_q <= o_inst_addr_o;
        end
        if (accept) begin
            req_addr_q <= o_inst_addr_o;
        end
        if (resp_ok) begin
            inst_o      <= i_inst_readdata_i;
            inst_addr_o <= req_addr_q;
        end
    end

    // only one request in flight
    valid_needs_req_a: assert property (
        @(posedge clk) disable iff (reset_i)
        i_inst_readdata_valid_i |-> state_q != ST_REQ
    );

    addr_stable_a: assert property (
        @(posedge clk) disable iff (reset_i)
        o_inst_read_o && i_inst_waitrequest_i |=> o_inst_read_o && $stable(o_inst_addr_o)
    );

endmodule

//--- src/id.sv
`include "rv32i_consts.svh"

module id (
    input  rv32i_pkg::word_t     inst_i,
    output rv32i_pkg::reg_addr_t rs1_o,
    output rv32i_pkg::reg_addr_t rs2_o,
    output rv32i_pkg::reg_addr_t rd_o,
    output rv32i_pkg::word_t     imm_o,
    output logic                 use_imm_o,
    output rv32i_pkg::op_sel_e   op1_sel_o,
    output rv32i_pkg::alu_op_e   alu_op_o,
    output rv32i_pkg::br_op_e    br_op_o,
    output logic                 reg_we_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               alt;    // bit 30, sub and sra
    rv32i_pkg::word_t   imm_i_type;
    rv32i_pkg::word_t   imm_u_type;
    rv32i_pkg::word_t   imm_b_type;
    rv32i_pkg::word_t   imm_j_type;
    rv32i_pkg::alu_op_e f3_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign alt    = inst_i[30];
    assign rd_o   = inst_i[11:7];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        case (funct3)
            `F3_ADD_SUB: f3_op = rv32i_pkg::ALU_ADD;
            `F3_SLL:     f3_op = rv32i_pkg::ALU_SLL;
            `F3_SLT:     f3_op = rv32i_pkg::ALU_SLT;
            `F3_SLTU:    f3_op = rv32i_pkg::ALU_SLTU;
            `F3_XOR:     f3_op = rv32i_pkg::ALU_XOR;
            `F3_SRL_SRA: f3_op = alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
            `F3_OR:      f3_op = rv32i_pkg::ALU_OR;
            default:     f3_op = rv32i_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        imm_o     = '0;
        use_imm_o = 1'b0;
        op1_sel_o = rv32i_pkg::OP1_REG;
        alu_op_o  = rv32i_pkg::ALU_ADD;
        br_op_o   = rv32i_pkg::BR_NONE;
        reg_we_o  = 1'b0;
        case (opcode)
            `OPC_OP: begin
                reg_we_o = 1'b1;
                alu_op_o = (funct3 == `F3_ADD_SUB && alt) ? rv32i_pkg::ALU_SUB : f3_op;
            end
            `OPC_OP_IMM: begin
                reg_we_o  = 1'b1;
                use_imm_o = 1'b1;
                imm_o     = imm_i_type;     // shamt sits in the low bits
                alu_op_o  = f3_op;
            end
            `OPC_LUI: begin
                reg_we_o  = 1'b1;
                use_imm_o = 1'b1;
                imm_o     = imm_u_type;
                op1_sel_o = rv32i_pkg::OP1_ZERO;
            end
            `OPC_AUIPC: begin
                reg_we_o  = 1'b1;
                use_imm_o = 1'b1;
                imm_o     = imm_u_type;
                op1_sel_o = rv32i_pkg::OP1_PC;
            end
            `OPC_BRANCH: begin
                imm_o = imm_b_type;
                case (funct3)
                    `F3_BEQ: br_op_o = rv32i_pkg::BR_EQ;
                    `F3_BNE: br_op_o = rv32i_pkg::BR_NE;
                    `F3_BLT: br_op_o = rv32i_pkg::BR_LT;
                    `F3_BGE: br_op_o = rv32i_pkg::BR_GE;
                    default: br_op_o = rv32i_pkg::BR_NONE;
                endcase
            end
            `OPC_JAL: begin
                reg_we_o = 1'b1;
                imm_o    = imm_j_type;
                br_op_o  = rv32i_pkg::BR_JAL;
            end
            `OPC_JALR: begin
                reg_we_o = 1'b1;
                imm_o    = imm_i_type;
                br_op_o  = rv32i_pkg::BR_JALR;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/regs.sv
`include "rv32i_consts.svh"

module regs (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 we_i,
    input  rv32i_pkg::reg_addr_t waddr_i,
    input  rv32i_pkg::word_t     wdata_i,
    input  rv32i_pkg::reg_addr_t raddr1_i,
    input  rv32i_pkg::reg_addr_t raddr2_i,
    output rv32i_pkg::word_t     rdata1_o,
    output rv32i_pkg::word_t     rdata2_o,
    input  rv32i_pkg::reg_addr_t jtag_reg_addr_i,
    output rv32i_pkg::word_t     jtag_reg_data_o
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_W;

    rv32i_pkg::word_t rf_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            rf_q[waddr_i] <= wdata_i;   // x0 stays zero
        end
    end

    // written at the edge and seen by the next instruction
    assign rdata1_o        = rf_q[raddr1_i];
    assign rdata2_o        = rf_q[raddr2_i];
    assign jtag_reg_data_o = rf_q[jtag_reg_addr_i];

endmodule

//--- src/ex.sv
`include "rv32i_consts.svh"

module ex (
    input  logic                 inst_valid_i,
    input  rv32i_pkg::word_t     inst_addr_i,
    input  rv32i_pkg::word_t     rs1_data_i,
    input  rv32i_pkg::word_t     rs2_data_i,
    input  rv32i_pkg::word_t     imm_i,
    input  logic                 use_imm_i,
    input  rv32i_pkg::op_sel_e   op1_sel_i,
    input  rv32i_pkg::alu_op_e   alu_op_i,
    input  rv32i_pkg::br_op_e    br_op_i,
    input  logic                 reg_we_i,
    input  rv32i_pkg::reg_addr_t rd_i,
    output logic                 reg_we_o,
    output rv32i_pkg::reg_addr_t reg_waddr_o,
    output rv32i_pkg::word_t     reg_wdata_o,
    output logic                 jump_flag_o,
    output rv32i_pkg::word_t     jump_addr_o
);

    localparam int SHAMT_W = $clog2(`XLEN);

    rv32i_pkg::word_t     op1;
    rv32i_pkg::word_t     op2;
    rv32i_pkg::word_t     alu_res;
    rv32i_pkg::word_t     link;
    rv32i_pkg::word_t     target;
    logic [SHAMT_W-1:0]   shamt;
    logic                 is_jump;
    logic                 taken;

    always_comb begin
        case (op1_sel_i)
            rv32i_pkg::OP1_PC:   op1 = inst_addr_i;
            rv32i_pkg::OP1_ZERO: op1 = '0;
            default:             op1 = rs1_data_i;
        endcase
    end

    assign op2   = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (alu_op_i)
            rv32i_pkg::ALU_SUB:  alu_res = op1 - op2;
            rv32i_pkg::ALU_AND:  alu_res = op1 & op2;
            rv32i_pkg::ALU_OR:   alu_res = op1 | op2;
            rv32i_pkg::ALU_XOR:  alu_res = op1 ^ op2;
            rv32i_pkg::ALU_SLT:  alu_res = rv32i_pkg::word_t'($signed(op1) < $signed(op2));
            rv32i_pkg::ALU_SLTU: alu_res = rv32i_pkg::word_t'(op1 < op2);
            rv32i_pkg::ALU_SLL:  alu_res = op1 << shamt;
            rv32i_pkg::ALU_SRL:  alu_res = op1 >> shamt;
            rv32i_pkg::ALU_SRA:  alu_res = $signed(op1) >>> shamt;
            default:             alu_res = op1 + op2;
        endcase
    end

    // branches compare the raw register values
    always_comb begin
        case (br_op_i)
            rv32i_pkg::BR_EQ:   taken = rs1_data_i == rs2_data_i;
            rv32i_pkg::BR_NE:   taken = rs1_data_i != rs2_data_i;
            rv32i_pkg::BR_LT:   taken = $signed(rs1_data_i) < $signed(rs2_data_i);
            rv32i_pkg::BR_GE:   taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
            rv32i_pkg::BR_JAL,
            rv32i_pkg::BR_JALR: taken = 1'b1;
            default:            taken = 1'b0;
        endcase
    end

    assign is_jump = (br_op_i == rv32i_pkg::BR_JAL) || (br_op_i == rv32i_pkg::BR_JALR);
    assign link    = inst_addr_i + 32'd4;
    assign target  = (br_op_i == rv32i_pkg::BR_JALR) ?
                     ((rs1_data_i + imm_i) & ~rv32i_pkg::word_t'(1)) :
                     inst_addr_i + imm_i;

    assign reg_we_o    = inst_valid_i && reg_we_i;
    assign reg_waddr_o = inst_valid_i ? rd_i : '0;
    assign reg_wdata_o = inst_valid_i ? (is_jump ? link : alu_res) : '0;
    assign jump_flag_o = inst_valid_i && taken;
    assign jump_addr_o = inst_valid_i ? target : '0;

endmodule

//--- src/rv32i.sv
module rv32i (
    input  logic                 clk,
    input  logic                 reset_i,
    output rv32i_pkg::word_t     o_inst_addr_o,
    output logic                 o_inst_read_o,
    input  logic                 i_inst_waitrequest_i,
    input  rv32i_pkg::word_t     i_inst_readdata_i,
    input  logic                 i_inst_readdata_valid_i,
    input  rv32i_pkg::reg_addr_t jtag_reg_addr_i,
    output rv32i_pkg::word_t     jtag_reg_data_o
);

    rv32i_pkg::word_t     pc;
    logic                 pc_step;
    logic                 jump_flag;
    rv32i_pkg::word_t     jump_addr;
    rv32i_pkg::word_t     inst;
    rv32i_pkg::word_t     inst_addr;
    logic                 inst_valid;
    rv32i_pkg::reg_addr_t rs1;
    rv32i_pkg::reg_addr_t rs2;
    rv32i_pkg::reg_addr_t rd;
    rv32i_pkg::word_t     imm;
    logic                 use_imm;
    rv32i_pkg::op_sel_e   op1_sel;
    rv32i_pkg::alu_op_e   alu_op;
    rv32i_pkg::br_op_e    br_op;
    logic                 id_reg_we;
    rv32i_pkg::word_t     rs1_data;
    rv32i_pkg::word_t     rs2_data;
    logic                 reg_we;
    rv32i_pkg::reg_addr_t reg_waddr;
    rv32i_pkg::word_t     reg_wdata;

    pc_reg u_pc_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_step_i   (pc_step),
        .jump_flag_i (jump_flag),
        .jump_addr_i (jump_addr),
        .pc_o        (pc)
    );

    fetch_fsm u_fetch_fsm (
        .clk                     (clk),
        .reset_i                 (reset_i),
        .pc_i                    (pc),
        .jump_flag_i             (jump_flag),
        .o_inst_addr_o           (o_inst_addr_o),
        .o_inst_read_o           (o_inst_read_o),
        .i_inst_waitrequest_i    (i_inst_waitrequest_i),
        .i_inst_readdata_i       (i_inst_readdata_i),
        .i_inst_readdata_valid_i (i_inst_readdata_valid_i),
        .pc_step_o               (pc_step),
        .inst_o                  (inst),
        .inst_addr_o             (inst_addr),
        .inst_valid_o            (inst_valid)
    );

    id u_id (
        .inst_i    (inst),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rd_o      (rd),
        .imm_o     (imm),
        .use_imm_o (use_imm),
        .op1_sel_o (op1_sel),
        .alu_op_o  (alu_op),
        .br_op_o   (br_op),
        .reg_we_o  (id_reg_we)
    );

    regs u_regs (
        .clk             (clk),
        .reset_i         (reset_i),
        .we_i            (reg_we),
        .waddr_i         (reg_waddr),
        .wdata_i         (reg_wdata),
        .raddr1_i        (rs1),
        .raddr2_i        (rs2),
        .rdata1_o        (rs1_data),
        .rdata2_o        (rs2_data),
        .jtag_reg_addr_i (jtag_reg_addr_i),
        .jtag_reg_data_o (jtag_reg_data_o)
    );

    ex u_ex (
        .inst_valid_i (inst_valid),
        .inst_addr_i  (inst_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i        (imm),
        .use_imm_i    (use_imm),
        .op1_sel_i    (op1_sel),
        .alu_op_i     (alu_op),
        .br_op_i      (br_op),
        .reg_we_i     (id_reg_we),
        .rd_i         (rd),
        .reg_we_o     (reg_we),
        .reg_waddr_o  (reg_waddr),
        .reg_wdata_o  (reg_wdata),
        .jump_flag_o  (jump_flag),
        .jump_addr_o  (jump_addr)
    );

endmodule

//--- test/tb_rv32i.sv
`include "rv32i_consts.svh"

module tb_rv32i;

    localparam int MEM_WORDS    = 64;
    localparam int PROG_LEN     = 43;
    localparam int WORST_CYCLES = 16;   // 3 waits, accept, 3 delay, one dropped response
    localparam int TIMEOUT      = (5 + PROG_LEN * WORST_CYCLES + 64) * 10;

    logic              clk;
    logic              reset_i;
    logic [`XLEN-1:0]  inst_addr;
    logic              inst_read;
    logic              mem_waitrequest;
    logic [`XLEN-1:0]  mem_rdata;
    logic              mem_rvalid;
    logic [4:0]        jtag_reg_addr_i;
    logic [`XLEN-1:0]  jtag_data;

    logic [`XLEN-1:0]  prog [MEM_WORDS];
    logic [`XLEN-1:0]  exp_regs [32];
    logic [`XLEN-1:0]  req_addr;
    logic [`XLEN-1:0]  end_pc;
    logic              pending;
    logic              first_read;
    int                delay_left;
    int                wait_left;
    int                loop_hits;
    int                seed = 16;

    rv32i rv32i_i (
        .clk                     (clk),
        .reset_i                 (reset_i),
        .o_inst_addr_o           (inst_addr),
        .o_inst_read_o           (inst_read),
        .i_inst_waitrequest_i    (mem_waitrequest),
        .i_inst_readdata_i       (mem_rdata),
        .i_inst_readdata_valid_i (mem_rvalid),
        .jtag_reg_addr_i         (jtag_reg_addr_i),
        .jtag_reg_data_o         (jtag_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] r_word(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                           int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic logic [31:0] imm_word(int imm, int rs1, logic [2:0] f3, int rd,
                                             logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] upper_word(int imm, int rd, logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] branch_word(int off, int rs2, int rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jump_word(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OPC_JAL};
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = 32'ha5a5_0000 | (i << 2);     // low bits 00, never a valid opcode
        end
        prog[0]  = imm_word(5, 0, `F3_ADD_SUB, 1, `OPC_OP_IMM);
        prog[1]  = imm_word(-3, 0, `F3_ADD_SUB, 2, `OPC_OP_IMM);
        prog[2]  = r_word(7'h00, 2, 1, `F3_ADD_SUB, 3);
        prog[3]  = r_word(7'h20, 1, 2, `F3_ADD_SUB, 4);   // sub
        prog[4]  = r_word(7'h00, 2, 1, `F3_AND, 5);
        prog[5]  = r_word(7'h00, 2, 1, `F3_OR, 6);
        prog[6]  = r_word(7'h00, 2, 1, `F3_XOR, 7);
        prog[7]  = r_word(7'h00, 1, 2, `F3_SLT, 8);
        prog[8]  = r_word(7'h00, 1, 2, `F3_SLTU, 9);
        prog[9]  = r_word(7'h00, 1, 1, `F3_SLL, 10);
        prog[10] = r_word(7'h00, 1, 2, `F3_SRL_SRA, 11);
        prog[11] = r_word(7'h20, 1, 2, `F3_SRL_SRA, 12);  // sra
        prog[12] = imm_word(-2, 2, `F3_SLT, 13, `OPC_OP_IMM);
        prog[13] = imm_word(-1, 1, `F3_SLTU, 14, `OPC_OP_IMM);
        prog[14] = imm_word(12'h7ff, 1, `F3_XOR, 15, `OPC_OP_IMM);
        prog[15] = imm_word(12'h100, 2, `F3_OR, 16, `OPC_OP_IMM);
        prog[16] = imm_word(12'h0f0, 2, `F3_AND, 17, `OPC_OP_IMM);
        prog[17] = imm_word(20, 1, `F3_SLL, 18, `OPC_OP_IMM);
        prog[18] = imm_word(4, 2, `F3_SRL_SRA, 19, `OPC_OP_IMM);
        prog[19] = imm_word(12'h401, 2, `F3_SRL_SRA, 20, `OPC_OP_IMM);  // srai
        prog[20] = upper_word(20'habcde, 21, `OPC_LUI);
        prog[21] = upper_word(20'h12345, 22, `OPC_AUIPC);
        prog[22] = imm_word(7, 1, `F3_ADD_SUB, 0, `OPC_OP_IMM);    // x0 must stay 0
        prog[23] = branch_word(8, 1, 1, `F3_BEQ);
        prog[24] = imm_word(99, 0, `F3_ADD_SUB, 23, `OPC_OP_IMM);
        prog[25] = branch_word(8, 1, 1, `F3_BNE);
        prog[26] = imm_word(1, 0, `F3_ADD_SUB, 24, `OPC_OP_IMM);
        prog[27] = branch_word(8, 1, 2, `F3_BLT);
        prog[28] = imm_word(2, 0, `F3_ADD_SUB, 24, `OPC_OP_IMM);
        prog[29] = branch_word(8, 1, 2, `F3_BGE);
        prog[30] = imm_word(3, 0, `F3_ADD_SUB, 25, `OPC_OP_IMM);
        prog[31] = branch_word(8, 2, 1, `F3_BGE);
        prog[32] = imm_word(4, 0, `F3_ADD_SUB, 25, `OPC_OP_IMM);
        prog[33] = branch_word(8, 2, 1, `F3_BLT);
        prog[34] = imm_word(5, 0, `F3_ADD_SUB, 26, `OPC_OP_IMM);
        prog[35] = jump_word(8, 27);
        prog[36] = imm_word(6, 0, `F3_ADD_SUB, 26, `OPC_OP_IMM);
        prog[37] = imm_word(160, 0, `F3_ADD_SUB, 28, `OPC_OP_IMM);
        prog[38] = imm_word(5, 28, 3'b000, 29, `OPC_JALR);      // odd sum, bit 0 cleared
        prog[39] = imm_word(7, 0, `F3_ADD_SUB, 30, `OPC_OP_IMM);
        prog[40] = imm_word(8, 0, `F3_ADD_SUB, 30, `OPC_OP_IMM);
        prog[41] = imm_word(1, 29, `F3_ADD_SUB, 31, `OPC_OP_IMM);
        prog[42] = jump_word(0, 0);                               // end loop
    endtask

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            `F3_ADD_SUB: return alt ? a - b : a + b;
            `F3_SLL:     return a << b[4:0];
            `F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            `F3_SLTU:    return {31'b0, a < b};
            `F3_XOR:     return a ^ b;
            `F3_SRL_SRA: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            `F3_OR:      return a | b;
            default:     return a & b;
        endcase
    endfunction

    // ISA model fills exp_regs and returns the end loop pc
    function automatic logic [31:0] run_reference();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] in;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] next_pc;
        logic [31:0] rd_val;
        logic [31:0] a;
        logic [31:0] b;
        logic        rd_we;
        logic        taken;
        pc = `RESET_PC;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        for (int step = 0; step < 4 * MEM_WORDS; step++) begin
            in = prog[pc[7:2]];
            if (in == jump_word(0, 0)) begin
                break;
            end
            imm_i   = {{20{in[31]}}, in[31:20]};
            imm_b   = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
            imm_j   = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
            a       = x[in[19:15]];
            b       = x[in[24:20]];
            next_pc = pc + 4;
            rd_we   = 1'b1;
            rd_val  = '0;
            taken   = 1'b0;
            case (in[6:0])
                `OPC_OP:     rd_val = alu_ref(in[14:12], in[30], a, b);
                `OPC_OP_IMM: rd_val = alu_ref(in[14:12], in[30] && in[14:12] == `F3_SRL_SRA,
                                              a, imm_i);
                `OPC_LUI:    rd_val = {in[31:12], 12'b0};
                `OPC_AUIPC:  rd_val = pc + {in[31:12], 12'b0};
                `OPC_BRANCH: begin
                    rd_we = 1'b0;
                    case (in[14:12])
                        `F3_BEQ: taken = a == b;
                        `F3_BNE: taken = a != b;
                        `F3_BLT: taken = $signed(a) < $signed(b);
                        `F3_BGE: taken = $signed(a) >= $signed(b);
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        next_pc = pc + imm_b;
                    end
                end
                `OPC_JAL: begin
                    rd_val  = pc + 4;
                    next_pc = pc + imm_j;
                end
                `OPC_JALR: begin
                    rd_val  = pc + 4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: rd_we = 1'b0;
            endcase
            if (rd_we && in[11:7] != 5'd0) begin
                x[in[11:7]] = rd_val;
            end
            pc = next_pc;
        end
        for (int r = 0; r < 32; r++) begin
            exp_regs[r] = x[r];
        end
        return pc;
    endfunction

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got 0x%h expected 0x%h", what, got, exp));
        end
    endtask

    // memory model and reset
    initial begin
        reset_i         = 1'b1;
        mem_waitrequest = 1'b0;
        mem_rdata       = '0;
        mem_rvalid      = 1'b0;
        pending         = 1'b0;
        first_read      = 1'b1;
        delay_left      = 0;
        wait_left       = 0;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        forever begin
            mem_rvalid = 1'b0;
            mem_rdata  = '0;
            if (pending && delay_left == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = prog[req_addr[7:2]];
                pending    = 1'b0;
            end else if (pending) begin
                delay_left--;
            end
            mem_waitrequest = wait_left != 0;
            #1;     // let the core's strobes settle
            if (first_read) begin
                check_value("o_inst_read_o", {31'b0, inst_read}, 32'd1);
                check_value("o_inst_addr_o", inst_addr, `RESET_PC);
                first_read = 1'b0;
            end
            if (inst_read) begin
                check_value("o_inst_addr_o[1:0]", {30'b0, inst_addr[1:0]}, 32'd0);
                if (mem_waitrequest) begin
                    wait_left--;
                end else begin
                    if (pending) begin
                        fail_run("core issued a second request while one was outstanding");
                    end
                    pending    = 1'b1;
                    req_addr   = inst_addr;
                    delay_left = $random(seed) & 3;
                    wait_left  = $random(seed) & 3;
                end
            end
            @(negedge clk);
        end
    end

    initial begin
        jtag_reg_addr_i = '0;
        load_program();
        end_pc    = run_reference();
        loop_hits = 0;
        while (loop_hits < 2) begin
            @(negedge clk);
            if (rv32i_i.inst_valid && rv32i_i.inst_addr == end_pc) begin
                loop_hits++;
            end
        end
        for (int r = 0; r < 32; r++) begin
            jtag_reg_addr_i = 5'(r);
            @(negedge clk);
            check_value($sformatf("jtag_reg_data_o x%0d", r), jtag_data, exp_regs[r]);
        end
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        fail_run("core did not reach the end loop before the timeout");
    end

endmodule

//--- all.f
+incdir+include
src/rv32i_pkg.sv
src/pc_reg.sv
src/fetch_fsm.sv
src/id.sv
src/regs.sv
src/ex.sv
src/rv32i.sv
test/tb_rv32i.sv

//--- Bender.yml
package:
  name: rv32i

sources:
  - include_dirs:
      - include
    files:
      - src/rv32i_pkg.sv
      - src/pc_reg.sv
      - src/fetch_fsm.sv
      - src/id.sv
      - src/regs.sv
      - src/ex.sv
      - src/rv32i.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_rv32i.sv
